//--- Makefile
SIM      ?= verilator
TOP      ?= cp0_tb
FILELIST ?= verilog.f
FLAGS    ?= --binary --timing --assert
LOG      ?= sim.log
OBJ_DIR  ?= obj_dir

.PHONY: lint sim clean

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/commit_unit.sv
`timescale 1ns/1ps

module commit_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  mips_pkg::retire_t [1:0]     retire,
    input  mips_pkg::cp0_status_t       cp0_status,
    input  mips_pkg::cp0_cause_t        cp0_cause,
    output mips_pkg::rf_w_t [1:0]       cwrite,
    output mips_pkg::exception_t        exception,
    output logic                        is_eret
);
    import mips_pkg::*;

    logic int_pending;
    logic exc1;
    logic eret1;
    logic kill0;
    logic int0;
    logic exc0;
    logic eret_next;
    rf_w_t [1:0] cwrite_next;
    exception_t exception_next;

    // enabled, not at exception level, and an unmasked pending bit
    assign int_pending = cp0_status.IE & ~cp0_status.EXL & ~cp0_status.ERL
                       & (|(cp0_status.IM & cp0_cause.IP));

    // slot 1 is the older slot and takes the interrupt when valid
    assign exc1  = retire[1].valid & (retire[1].exc_valid | int_pending);
    assign eret1 = retire[1].valid & retire[1].is_eret & ~exc1;

    // eret has no delay slot so the younger instruction is dropped
    assign kill0 = exc1 | eret1;
    assign int0  = int_pending & ~retire[1].valid;
    assign exc0  = retire[0].valid & ~kill0 & (retire[0].exc_valid | int0);

    always_comb begin
        cwrite_next[1].wen  = retire[1].valid & retire[1].is_mtc0 & ~exc1;
        cwrite_next[1].addr = retire[1].cwa;
        cwrite_next[1].wd   = retire[1].cwd;

        cwrite_next[0].wen  = retire[0].valid & retire[0].is_mtc0 & ~kill0 & ~exc0;
        cwrite_next[0].addr = retire[0].cwa;
        cwrite_next[0].wd   = retire[0].cwd;

        eret_next = eret1 | (retire[0].valid & retire[0].is_eret & ~kill0 & ~exc0);

        if (exc1) begin
            exception_next.valid         = 1'b1;
            exception_next.in_delay_slot = retire[1].in_delay_slot;
            exception_next.code          = int_pending ? EXC_INT : retire[1].exc_code;
            exception_next.pc            = retire[1].pc;
            exception_next.badvaddr      = retire[1].badvaddr;
        end else begin
            exception_next.valid         = exc0;
            exception_next.in_delay_slot = retire[0].in_delay_slot;
            exception_next.code          = int0 ? EXC_INT : retire[0].exc_code;
            exception_next.pc            = retire[0].pc;
            exception_next.badvaddr      = retire[0].badvaddr;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            cwrite    <= '0;
            exception <= '0;
            is_eret   <= 1'b0;
        end else begin
            cwrite    <= cwrite_next;
            exception <= exception_next;
            is_eret   <= eret_next;
        end
    end

    // cp0 never sees an eret and an exception in the same cycle
    assert property (@(posedge clk) disable iff (!reset)
        !(is_eret && exception.valid))
        else $error("commit_unit: eret issued together with an exception");

endmodule

//--- hw/cp0.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module cp0 (
    input  logic                         clk,
    input  logic                         reset,
    input  mips_pkg::rf_w_t [1:0]        cwrite,
    input  mips_pkg::creg_addr_t [1:0]   ra,
    output mips_pkg::word_t [1:0]        rd,
    input  logic                         is_eret,
    input  mips_pkg::exception_t         exception,
    output logic                         timer_interrupt,
    output mips_pkg::cp0_status_t        cp0_status,
    output mips_pkg::cp0_cause_t         cp0_cause,
    output mips_pkg::word_t              cp0_epc
);
    import mips_pkg::*;

    cp0_regs_t regs;
    cp0_regs_t regs_new;
    logic count_switch;
    logic compare_written;

    function automatic word_t read_reg(cp0_regs_t r, creg_addr_t a);
        word_t d;
        case (a)
            `CREG_BADVADDR: d = r.badvaddr;
            `CREG_COUNT:    d = r.count;
            `CREG_COMPARE:  d = r.compare;
            `CREG_STATUS:   d = r.status;
            `CREG_CAUSE:    d = r.cause;
            `CREG_EPC:      d = r.epc;
            `CREG_CONFIG:   d = r.config_;
            default:        d = '0;
        endcase
        return d;
    endfunction

    // only the software-writable fields move
    function automatic cp0_regs_t apply_write(cp0_regs_t r, rf_w_t w);
        cp0_regs_t n;
        n = r;
        if (w.wen) begin
            case (w.addr)
                `CREG_COUNT:   n.count = w.wd;
                `CREG_COMPARE: n.compare = w.wd;
                `CREG_STATUS: begin
                    n.status.IM  = w.wd[15:8];
                    n.status.EXL = w.wd[1];
                    n.status.IE  = w.wd[0];
                end
                `CREG_CAUSE:   n.cause.IP[1:0] = w.wd[9:8];
                `CREG_EPC:     n.epc = w.wd;
                default: ;
            endcase
        end
        return n;
    endfunction

    always_ff @(posedge clk) begin
        if (!reset) begin
            regs         <= `CP0_INIT;
            count_switch <= 1'b1;
        end else begin
            regs         <= regs_new;
            count_switch <= ~count_switch;
        end
    end

    assign compare_written = (cwrite[1].wen && cwrite[1].addr == `CREG_COMPARE)
                          || (cwrite[0].wen && cwrite[0].addr == `CREG_COMPARE);

    always_comb begin
        regs_new = regs;

        // count ticks every other cycle
        regs_new.count = regs.count + {31'b0, count_switch};

        // older slot first so slot 0 wins on a shared register
        regs_new = apply_write(regs_new, cwrite[1]);
        regs_new = apply_write(regs_new, cwrite[0]);

        if (exception.valid) begin
            // epc and bd stay put on a nested exception
            if (!regs.status.EXL) begin
                regs_new.cause.BD = exception.in_delay_slot;
                if (exception.in_delay_slot) begin
                    regs_new.epc = exception.pc - 32'd4;
                end else begin
                    regs_new.epc = exception.pc;
                end
            end
            regs_new.cause.exccode = exception.code;
            regs_new.status.EXL = 1'b1;
            if (exception.code == `CODE_ADEL || exception.code == `CODE_ADES) begin
                regs_new.badvaddr = exception.badvaddr;
            end
        end

        if (is_eret) begin
            regs_new.status.EXL = 1'b0;
        end

        // timer line lives in cause IP[7]
        if (regs_new.count == regs_new.compare - 32'd1) begin
            regs_new.cause.IP[7] = 1'b1;
        end else if (compare_written) begin
            regs_new.cause.IP[7] = 1'b0;
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rd[i] = read_reg(regs, ra[i]);
        end
    end

    assign timer_interrupt = regs.cause.IP[7];
    assign cp0_status      = regs.status;
    assign cp0_cause       = regs.cause;
    assign cp0_epc         = regs.epc;

    for (genvar i = 0; i < 2; i++) begin : g_read_check
        assert property (@(posedge clk) disable iff (!reset)
            !(ra[i] inside {`CREG_BADVADDR, `CREG_COUNT, `CREG_COMPARE, `CREG_STATUS,
                            `CREG_CAUSE, `CREG_EPC, `CREG_CONFIG}) |-> rd[i] == '0)
            else $error("cp0: read port %0d nonzero for address %0d", i, ra[i]);
    end

    // commit unit keeps eret apart from exceptions, so EXL must stick
    assert property (@(posedge clk) disable iff (!reset)
        exception.valid |=> cp0_status.EXL)
        else $error("cp0: EXL not set after exception");

endmodule

//--- hw/cp0_subsystem_top.sv
`timescale 1ns/1ps

module cp0_subsystem_top (
    input  logic                        clk,
    input  logic                        reset,
    input  mips_pkg::retire_t [1:0]     retire,
    input  mips_pkg::creg_addr_t [1:0]  ra,
    output mips_pkg::word_t [1:0]       rd,
    output logic                        redirect_valid,
    output mips_pkg::word_t             redirect_pc,
    output logic                        timer_interrupt
);
    import mips_pkg::*;

    rf_w_t [1:0] cwrite;
    exception_t exception;
    logic is_eret;
    cp0_status_t cp0_status;
    cp0_cause_t cp0_cause;
    word_t cp0_epc;

    commit_unit commit_unit_inst (
        .clk        (clk),
        .reset      (reset),
        .retire     (retire),
        .cp0_status (cp0_status),
        .cp0_cause  (cp0_cause),
        .cwrite     (cwrite),
        .exception  (exception),
        .is_eret    (is_eret)
    );

    cp0 cp0_inst (
        .clk             (clk),
        .reset           (reset),
        .cwrite          (cwrite),
        .ra              (ra),
        .rd              (rd),
        .is_eret         (is_eret),
        .exception       (exception),
        .timer_interrupt (timer_interrupt),
        .cp0_status      (cp0_status),
        .cp0_cause       (cp0_cause),
        .cp0_epc         (cp0_epc)
    );

    pc_redirect pc_redirect_inst (
        .clk             (clk),
        .reset           (reset),
        .exception_valid (exception.valid),
        .is_eret         (is_eret),
        .epc             (cp0_epc),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc)
    );

endmodule

//--- hw/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// cp0 register record at reset
// field order is badvaddr, count, compare, status, cause, epc, config_
`define CP0_INIT {32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, \
                  32'h0000_0000, 32'h0000_0000, 32'h8000_0000}

// address error codes, load and store
`define CODE_ADEL 5'd4
`define CODE_ADES 5'd5

`define EXC_VECTOR 32'hbfc0_0380

// cp0 register numbers
`define CREG_BADVADDR 5'd8
`define CREG_COUNT    5'd9
`define CREG_COMPARE  5'd11
`define CREG_STATUS   5'd12
`define CREG_CAUSE    5'd13
`define CREG_EPC      5'd14
`define CREG_CONFIG   5'd16

`endif

//--- hw/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] creg_addr_t;

    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } exccode_t;

    // one cp0 write port
    typedef struct packed {
        logic       wen;
        creg_addr_t addr;
        word_t      wd;
    } rf_w_t;

    typedef struct packed {
        logic     valid;
        logic     in_delay_slot;
        exccode_t code;
        word_t    pc;
        word_t    badvaddr;
    } exception_t;

    typedef struct packed {
        logic [15:0] zero_hi;
        logic [7:0]  IM;
        logic [4:0]  zero_lo;
        logic        ERL;
        logic        EXL;
        logic        IE;
    } cp0_status_t;

    typedef struct packed {
        logic        BD;
        logic [14:0] zero_hi;
        logic [7:0]  IP;
        logic        zero_mid;
        logic [4:0]  exccode;
        logic [1:0]  zero_lo;
    } cp0_cause_t;

    typedef struct packed {
        word_t       badvaddr;
        word_t       count;
        word_t       compare;
        cp0_status_t status;
        cp0_cause_t  cause;
        word_t       epc;
        word_t       config_;
    } cp0_regs_t;

    // what one slot hands over when it retires
    typedef struct packed {
        logic       valid;
        logic       is_mtc0;
        logic       is_eret;
        logic       exc_valid;
        exccode_t   exc_code;
        logic       in_delay_slot;
        word_t      pc;
        word_t      badvaddr;
        creg_addr_t cwa;
        word_t      cwd;
    } retire_t;

endpackage

//--- hw/pc_redirect.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module pc_redirect (
    input  logic                clk,
    input  logic                reset,
    input  logic                exception_valid,
    input  logic                is_eret,
    input  mips_pkg::word_t     epc,
    output logic                redirect_valid,
    output mips_pkg::word_t     redirect_pc
);
    import mips_pkg::*;

    word_t target;

    // exception wins over eret
    always_comb begin
        if (exception_valid) begin
            target = `EXC_VECTOR;
        end else begin
            target = epc;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= exception_valid | is_eret;
        end
    end

    // target only loads on an event
    always_ff @(posedge clk) begin
        if (exception_valid || is_eret) begin
            redirect_pc <= target;
        end
    end

    // one strobe cycle per event
    assert property (@(posedge clk) disable iff (!reset)
        redirect_valid |-> $past(exception_valid || is_eret))
        else $error("pc_redirect: strobe without a matching event");

endmodule

//--- verification/cp0_tb.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module cp0_tb;
    import mips_pkg::*;

    localparam int RESET_CYCLES    = 8;
    localparam int DIRECTED_CYCLES = 97;
    localparam int RANDOM_PAIRS    = 300;
    localparam int TIMEOUT_NS      = (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_PAIRS + 50) * 8;

    logic clk = 1'b0;
    logic reset;
    retire_t [1:0] retire;
    creg_addr_t [1:0] ra = '0;
    word_t [1:0] rd;
    logic redirect_valid;
    word_t redirect_pc;
    logic timer_interrupt;

    integer seed = 32'hfb38;
    logic [4:0] rsel = '0;

    // shadow of the commit stage, the registers and the redirect stage
    cp0_regs_t m_regs;
    cp0_regs_t nx_regs;
    rf_w_t [1:0] m_cw;
    rf_w_t [1:0] nx_cw;
    exception_t m_exc;
    exception_t nx_exc;
    logic m_eret;
    logic nx_eret;
    logic m_tick;
    logic m_rv;
    word_t m_rpc;
    word_t exp_rd0;
    word_t exp_rd1;

    cp0_subsystem_top cp0_subsystem_top_inst (
        .clk             (clk),
        .reset           (reset),
        .retire          (retire),
        .ra              (ra),
        .rd              (rd),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .timer_interrupt (timer_interrupt)
    );

    always #4 clk = ~clk;

    // walk both read ports over the whole address space
    always @(posedge clk) begin
        #1;
        rsel  <= rsel + 5'd1;
        ra[0] <= rsel;
        ra[1] <= {rsel[1:0], rsel[4:2]};
    end

    function automatic word_t shadow_read(cp0_regs_t r, creg_addr_t a);
        word_t d;
        d = '0;
        if (a == `CREG_BADVADDR) d = r.badvaddr;
        if (a == `CREG_COUNT) d = r.count;
        if (a == `CREG_COMPARE) d = r.compare;
        if (a == `CREG_STATUS) d = r.status;
        if (a == `CREG_CAUSE) d = r.cause;
        if (a == `CREG_EPC) d = r.epc;
        if (a == `CREG_CONFIG) d = r.config_;
        return d;
    endfunction

    // masks hold the software-writable bits
    function automatic cp0_regs_t shadow_mtc0(cp0_regs_t r, rf_w_t w);
        cp0_regs_t n;
        n = r;
        if (w.wen && w.addr == `CREG_COUNT) n.count = w.wd;
        if (w.wen && w.addr == `CREG_COMPARE) n.compare = w.wd;
        if (w.wen && w.addr == `CREG_EPC) n.epc = w.wd;
        if (w.wen && w.addr == `CREG_STATUS)
            n.status = (r.status & ~32'h0000_ff03) | (w.wd & 32'h0000_ff03);
        if (w.wen && w.addr == `CREG_CAUSE)
            n.cause = (r.cause & ~32'h0000_0300) | (w.wd & 32'h0000_0300);
        return n;
    endfunction

    always_comb begin
        logic pend;
        logic take1;
        logic drop0;
        logic take0;
        retire_t pick;
        pend  = m_regs.status.IE && !m_regs.status.EXL && !m_regs.status.ERL
             && ((m_regs.status.IM & m_regs.cause.IP) != 8'd0);
        take1 = retire[1].valid && (retire[1].exc_valid || pend);
        drop0 = take1 || (retire[1].valid && retire[1].is_eret);
        take0 = retire[0].valid && !drop0 && (retire[0].exc_valid || (pend && !retire[1].valid));
        nx_cw[1].wen  = retire[1].valid && retire[1].is_mtc0 && !take1;
        nx_cw[1].addr = retire[1].cwa;
        nx_cw[1].wd   = retire[1].cwd;
        nx_cw[0].wen  = retire[0].valid && retire[0].is_mtc0 && !drop0 && !take0;
        nx_cw[0].addr = retire[0].cwa;
        nx_cw[0].wd   = retire[0].cwd;
        nx_eret = (retire[1].valid && retire[1].is_eret && !take1)
               || (retire[0].valid && retire[0].is_eret && !drop0 && !take0);
        pick = take1 ? retire[1] : retire[0];
        nx_exc.valid         = take1 || take0;
        nx_exc.in_delay_slot = pick.in_delay_slot;
        nx_exc.code          = pend ? EXC_INT : pick.exc_code;
        nx_exc.pc            = pick.pc;
        nx_exc.badvaddr      = pick.badvaddr;
    end

    always_comb begin
        logic cmp_wr;
        nx_regs = m_regs;
        nx_regs.count = m_regs.count + (m_tick ? 32'd1 : 32'd0);
        nx_regs = shadow_mtc0(nx_regs, m_cw[1]);
        nx_regs = shadow_mtc0(nx_regs, m_cw[0]);
        if (m_exc.valid) begin
            if (!m_regs.status.EXL) begin
                nx_regs.cause.BD = m_exc.in_delay_slot;
                nx_regs.epc = m_exc.in_delay_slot ? m_exc.pc - 32'd4 : m_exc.pc;
            end
            nx_regs.status.EXL = 1'b1;
            nx_regs.cause.exccode = m_exc.code;
            if (m_exc.code == EXC_ADEL || m_exc.code == EXC_ADES)
                nx_regs.badvaddr = m_exc.badvaddr;
        end
        if (m_eret) nx_regs.status.EXL = 1'b0;
        cmp_wr = (m_cw[1].wen && m_cw[1].addr == `CREG_COMPARE)
              || (m_cw[0].wen && m_cw[0].addr == `CREG_COMPARE);
        if (nx_regs.count + 32'd1 == nx_regs.compare) nx_regs.cause.IP[7] = 1'b1;
        else if (cmp_wr) nx_regs.cause.IP[7] = 1'b0;
    end

    always @(posedge clk) begin
        if (!reset) begin
            m_regs <= `CP0_INIT;
            m_tick <= 1'b1;
            m_cw   <= '0;
            m_exc  <= '0;
            m_eret <= 1'b0;
            m_rv   <= 1'b0;
        end else begin
            m_regs <= nx_regs;
            m_tick <= ~m_tick;
            m_cw   <= nx_cw;
            m_exc  <= nx_exc;
            m_eret <= nx_eret;
            m_rv   <= m_exc.valid | m_eret;
            if (m_exc.valid) m_rpc <= `EXC_VECTOR;
            else if (m_eret) m_rpc <= m_regs.epc;
        end
    end

    assign exp_rd0 = shadow_read(m_regs, ra[0]);
    assign exp_rd1 = shadow_read(m_regs, ra[1]);

    task automatic mismatch(input string name, input word_t exp, input word_t act);
        $display("ERR time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        $display("TEST RESULT: FAIL");
        $fatal(1, "value mismatch on %s", name);
    endtask

    assert property (@(posedge clk) disable iff (!reset) rd[0] == exp_rd0)
        else mismatch("rd[0]", $sampled(exp_rd0), $sampled(rd[0]));
    assert property (@(posedge clk) disable iff (!reset) rd[1] == exp_rd1)
        else mismatch("rd[1]", $sampled(exp_rd1), $sampled(rd[1]));
    assert property (@(posedge clk) disable iff (!reset) redirect_valid == m_rv)
        else mismatch("redirect_valid", {31'b0, $sampled(m_rv)},
                      {31'b0, $sampled(redirect_valid)});
    assert property (@(posedge clk) disable iff (!reset) redirect_valid |-> redirect_pc == m_rpc)
        else mismatch("redirect_pc", $sampled(m_rpc), $sampled(redirect_pc));
    assert property (@(posedge clk) disable iff (!reset) timer_interrupt == m_regs.cause.IP[7])
        else mismatch("timer_interrupt", {31'b0, $sampled(m_regs.cause.IP[7])},
                      {31'b0, $sampled(timer_interrupt)});

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish in %0d ns", TIMEOUT_NS);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    function automatic retire_t mtc0_op(creg_addr_t a, word_t d);
        retire_t s;
        s = '0;
        s.valid = 1'b1;
        s.is_mtc0 = 1'b1;
        s.cwa = a;
        s.cwd = d;
        s.pc = 32'h0000_0400;
        return s;
    endfunction

    function automatic retire_t nop_op(word_t pc);
        retire_t s;
        s = '0;
        s.valid = 1'b1;
        s.pc = pc;
        return s;
    endfunction

    function automatic retire_t exc_op(exccode_t c, word_t pc, logic ds, word_t bad);
        retire_t s;
        s = nop_op(pc);
        s.exc_valid = 1'b1;
        s.exc_code = c;
        s.in_delay_slot = ds;
        s.badvaddr = bad;
        return s;
    endfunction

    function automatic retire_t eret_op(word_t pc);
        retire_t s;
        s = nop_op(pc);
        s.is_eret = 1'b1;
        return s;
    endfunction

    task automatic drive_pair(input retire_t older, input retire_t younger);
        @(posedge clk);
        #1;
        retire[1] = older;
        retire[0] = younger;
    endtask

    task automatic idle(input int n);
        repeat (n) drive_pair('0, '0);
    endtask

    task automatic random_slot(input word_t pc, output retire_t s);
        integer k;
        creg_addr_t regs_list [8];
        exccode_t codes [7];
        regs_list = '{5'd8, 5'd9, 5'd11, 5'd12, 5'd13, 5'd14, 5'd16, 5'd3};
        codes = '{EXC_INT, EXC_ADEL, EXC_ADES, EXC_SYS, EXC_BP, EXC_RI, EXC_OV};
        s = '0;
        s.valid = ($random(seed) & 3) != 0;
        s.pc = pc;
        s.in_delay_slot = ($random(seed) & 1) != 0;
        k = $random(seed) & 15;
        if (k < 6) begin
            s.is_mtc0 = 1'b1;
            s.cwa = regs_list[$unsigned($random(seed)) % 8];
            s.cwd = $random(seed);
        end else if (k < 8) begin
            s.exc_valid = 1'b1;
            s.exc_code = codes[$unsigned($random(seed)) % 7];
            s.badvaddr = $random(seed);
        end else if (k == 8) begin
            s.is_eret = 1'b1;
        end
    endtask

    initial begin
        retire_t s1;
        retire_t s0;
        word_t pc;
        reset = 1'b0;
        retire = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b1;

        // writable fields only, then slot 0 wins on a shared register
        drive_pair(mtc0_op(`CREG_EPC, 32'h1234_5678), mtc0_op(`CREG_COMPARE, 32'hffff_0000));
        drive_pair(mtc0_op(`CREG_STATUS, 32'hffff_ffff), mtc0_op(`CREG_CAUSE, 32'hffff_ffff));
        idle(3);
        drive_pair(mtc0_op(`CREG_CAUSE, 32'h0), mtc0_op(`CREG_STATUS, 32'h0));
        drive_pair(mtc0_op(`CREG_EPC, 32'haaaa_0000), mtc0_op(`CREG_EPC, 32'hbbbb_0000));
        idle(3);

        // plain, nested and delay-slot exceptions
        drive_pair(exc_op(EXC_SYS, 32'h0000_1000, 1'b0, 32'h0), nop_op(32'h0000_1004));
        idle(3);
        drive_pair(nop_op(32'h0000_1100), exc_op(EXC_BP, 32'h0000_1104, 1'b1, 32'h0));
        idle(3);
        drive_pair(mtc0_op(`CREG_STATUS, 32'h0), '0);
        drive_pair(exc_op(EXC_RI, 32'h0000_2000, 1'b1, 32'h0), nop_op(32'h0000_2004));
        idle(3);

        // address errors, slot 0 mtc0 suppressed, slot 1 mtc0 kept
        drive_pair(mtc0_op(`CREG_STATUS, 32'h0), '0);
        drive_pair(exc_op(EXC_ADEL, 32'h0000_3000, 1'b0, 32'hdead_0001),
                   mtc0_op(`CREG_EPC, 32'h5555_5555));
        idle(3);
        drive_pair(mtc0_op(`CREG_STATUS, 32'h0), exc_op(EXC_ADES, 32'h0000_3104, 1'b0,
                   32'hbeef_0002));
        idle(3);
        drive_pair(exc_op(EXC_OV, 32'h0000_3200, 1'b0, 32'h1111_1111), '0);
        idle(3);

        // eret back to epc
        drive_pair(eret_op(32'h0000_4000), nop_op(32'h0000_4004));
        idle(3);
        drive_pair(nop_op(32'h0000_4100), eret_op(32'h0000_4104));
        idle(3);

        // timer, then the interrupt it raises
        drive_pair(mtc0_op(`CREG_COUNT, 32'd200), mtc0_op(`CREG_COMPARE, 32'd212));
        idle(30);
        drive_pair(mtc0_op(`CREG_STATUS, 32'h0000_8001), '0);
        idle(2);
        drive_pair(nop_op(32'h0000_5000), nop_op(32'h0000_5004));
        idle(3);
        drive_pair(mtc0_op(`CREG_COMPARE, 32'hffff_ff00), mtc0_op(`CREG_STATUS, 32'h0));
        idle(3);

        // software interrupt taken on the only valid slot
        drive_pair(mtc0_op(`CREG_CAUSE, 32'h0000_0100), mtc0_op(`CREG_STATUS, 32'h0000_0101));
        idle(2);
        drive_pair('0, nop_op(32'h0000_6004));
        idle(3);
        drive_pair(mtc0_op(`CREG_CAUSE, 32'h0), mtc0_op(`CREG_STATUS, 32'h0));
        idle(3);

        pc = 32'h0001_0000;
        for (int i = 0; i < RANDOM_PAIRS; i++) begin
            random_slot(pc, s1);
            random_slot(pc + 32'd4, s0);
            drive_pair(s1, s0);
            pc = pc + 32'd8;
        end
        idle(10);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+hw
hw/mips_pkg.sv
hw/commit_unit.sv
hw/cp0.sv
hw/pc_redirect.sv
hw/cp0_subsystem_top.sv
verification/cp0_tb.sv
